//--- branch_unit.f
+incdir+.
verilog/branch_pkg.sv
verilog/float_le_compare.sv
verilog/branch_compare_queue.sv
verilog/branch_order_queue.sv
verilog/return_addr_stack.sv
verilog/branch_unit.sv
tb/tb_branch_unit.sv

//--- tb/tb_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "branch_settings.svh"

module tb_branch_unit;
	import branch_pkg::*;

	localparam int depth = 2 ** `STACK_LOG;
	localparam int n_batch = 3; // branches per batch in the in-order test
	localparam int n_wait = 6;
	localparam int n_calls = 6;
	localparam int n_rounds = 2; // misprediction rounds
	localparam int n_trans = 4 * n_batch + 4 * n_wait + 8 + depth + 2 * n_calls + 14 * n_rounds;
	localparam int max_cycles = 40 * n_trans + 100;

	typedef addr_t [depth-1:0] stack_img_t;
	typedef struct packed {
		logic       fail;
		pattern_t   pat;
		addr_t      redir;
		stack_ptr_t sp;
		stack_img_t img; // whole stack at issue
	} branch_rec_t;

	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	cmp_kind_t cmp_kind;
	logic a_valid;
	tag_t a_tag;
	word_t a_data;
	logic b_valid;
	tag_t b_tag;
	word_t b_data;
	logic use_imm;
	logic [15:0] imm;
	logic prediction;
	pattern_t pattern_in;
	addr_t redirect_in;
	logic call_valid;
	logic call_ready;
	addr_t call_addr;
	logic ret;
	addr_t return_addr;
	logic commit_valid;
	logic commit_ready;
	logic failure;
	pattern_t pattern_out;
	addr_t redirect_addr;
	logic cdb_valid;
	tag_t cdb_tag;
	word_t cdb_data;

	int seed = 62;
	int errors = 0;
	int cycles = 0;
	stack_img_t model_stack;
	stack_ptr_t model_sp = '1;
	branch_rec_t model_q [$];
	branch_rec_t head_rec;

	branch_unit dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_pattern(input string name, input pattern_t got, input pattern_t exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// monotonic unsigned key, -0 folded onto +0
	function automatic logic [31:0] float_key(input word_t f);
		if (f[30:0] == 31'd0)
			return 32'h8000_0000;
		else if (f[31])
			return ~f;
		else
			return f | 32'h8000_0000;
	endfunction

	function automatic logic ref_taken(input cmp_kind_t kind, input word_t a, input word_t b);
		case (kind)
			cmp_eq:  return a == b;
			cmp_le:  return $signed(a) <= $signed(b);
			cmp_fle: return float_key(a) <= float_key(b);
			default: return a[30:23] == 8'h00;
		endcase
	endfunction

	function automatic word_t rand_float(input logic zero_exp);
		word_t f;
		f = $random(seed);
		if (f[30:23] == 8'hff)
			f[30] = 1'b0; // no NaN or inf
		if (zero_exp && f[0])
			f[30:23] = 8'h00;
		return f;
	endfunction

	task automatic issue_branch(
		input cmp_kind_t kind,
		input logic av,
		input word_t ad,
		input logic bv,
		input word_t bd,
		input logic ui,
		input logic [15:0] im,
		input logic pred,
		input logic strobe_a,
		input tag_t ta
	);
		word_t b_eff;
		branch_rec_t rec;
		b_eff = bd;
		if (ui && (kind == cmp_eq || kind == cmp_le))
			b_eff = {{16{im[15]}}, im};
		rec.fail  = pred ^ ref_taken(kind, ad, b_eff);
		rec.pat   = $random(seed);
		rec.redir = $random(seed);
		rec.sp    = model_sp;
		rec.img   = model_stack;
		issue_valid = 1'b1;
		cmp_kind    = kind;
		a_valid     = av;
		a_tag       = ta;
		a_data      = av ? ad : word_t'($random(seed)); // junk until broadcast
		b_valid     = bv;
		b_tag       = ta + 1'b1;
		b_data      = bv ? bd : word_t'($random(seed));
		use_imm     = ui;
		imm         = im;
		prediction  = pred;
		pattern_in  = rec.pat;
		redirect_in = rec.redir;
		cdb_valid   = strobe_a;
		cdb_tag     = ta;
		cdb_data    = ad;
		@(posedge clk);
		while (!issue_ready)
			@(posedge clk);
		@(negedge clk);
		issue_valid = 1'b0;
		cdb_valid   = 1'b0;
		model_q.push_back(rec);
	endtask

	task automatic issue_random_branch();
		logic [1:0] k;
		logic [3:0] coin;
		cmp_kind_t kind;
		word_t a;
		word_t b;
		logic [15:0] im;
		k    = $random(seed);
		coin = $random(seed);
		im   = $random(seed);
		kind = cmp_kind_t'(k);
		a    = $random(seed);
		b    = $random(seed);
		if (kind == cmp_fz || kind == cmp_fle) begin
			a = rand_float(kind == cmp_fz);
			b = coin[0] ? a : rand_float(1'b0);
			if (coin[2:1] == 2'b11) begin
				a = 32'h8000_0000; // negative zero against positive
				b = 32'h0;
			end
		end else if (coin[0]) begin
			a = {{16{im[15]}}, im};
		end
		issue_branch(kind, 1'b1, a, 1'b1, b, 1'b1, im, coin[3], 1'b0, tag_t'($random(seed)));
	endtask

	task automatic broadcast(input tag_t t, input word_t d);
		cdb_valid = 1'b1;
		cdb_tag   = t;
		cdb_data  = d;
		@(negedge clk);
		cdb_valid = 1'b0;
	endtask

	task automatic commit_head();
		while (!commit_ready)
			@(negedge clk);
		commit_valid = 1'b1;
		@(posedge clk);
		check_bit("issue_ready", issue_ready, 1'b1); // slot freed by this commit
		@(negedge clk);
		commit_valid = 1'b0;
	endtask

	task automatic do_call(input addr_t addr);
		call_valid = 1'b1;
		call_addr  = addr;
		@(posedge clk);
		while (!call_ready)
			@(posedge clk);
		@(negedge clk);
		call_valid = 1'b0;
		model_sp = model_sp + 1'b1;
		model_stack[model_sp] = addr;
		check_addr("return_addr", return_addr, model_stack[model_sp]);
	endtask

	task automatic do_ret();
		ret = 1'b1;
		@(negedge clk);
		ret = 1'b0;
		model_sp = model_sp - 1'b1;
		check_addr("return_addr", return_addr, model_stack[model_sp]);
	endtask

	// commit outputs against the branch model
	always @(posedge clk) begin
		if (!reset && commit_valid && commit_ready) begin
			if (model_q.size() == 0) begin
				errors++;
				$display("a commit was accepted with no branch left in the model");
			end else begin
				head_rec = model_q.pop_front();
				check_bit("failure", failure, head_rec.fail);
				check_pattern("pattern_out", pattern_out, head_rec.pat);
				check_addr("redirect_addr", redirect_addr, head_rec.redir);
				if (head_rec.fail) begin
					model_q.delete(); // wrong path gone
					model_sp    = head_rec.sp;
					model_stack = head_rec.img;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		int pick;
		logic [3:0] coin;
		logic early;
		logic b_wait;
		cmp_kind_t kind;
		word_t ad;
		word_t bd;
		tag_t ta;
		logic [15:0] im;
		logic pred;
		reset = 1'b1;
		issue_valid = 1'b0;
		cmp_kind = cmp_eq;
		a_valid = 1'b0;
		a_tag = '0;
		a_data = '0;
		b_valid = 1'b0;
		b_tag = '0;
		b_data = '0;
		use_imm = 1'b0;
		imm = '0;
		prediction = 1'b0;
		pattern_in = '0;
		redirect_in = '0;
		call_valid = 1'b0;
		call_addr = '0;
		ret = 1'b0;
		commit_valid = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_bit("issue_ready", issue_ready, 1'b1);
		check_bit("call_ready", call_ready, 1'b1);
		check_bit("commit_ready", commit_ready, 1'b0);

		// ready operands, in-order commit
		repeat (2) begin
			repeat (n_batch) issue_random_branch();
			while (model_q.size() > 0)
				commit_head();
		end

		// operands waiting on the result bus
		for (int i = 0; i < n_wait; i++) begin
			ta     = $random(seed);
			coin   = $random(seed);
			pick   = {$random(seed)} % 3;
			early  = coin[1];
			b_wait = early | coin[2];
			kind   = pick == 0 ? cmp_eq : (pick == 1 ? cmp_le : cmp_fle);
			ad     = $random(seed);
			bd     = coin[0] ? ad : word_t'($random(seed));
			if (kind == cmp_fle) begin
				ad = rand_float(1'b0);
				bd = coin[0] ? ad : rand_float(1'b0);
			end
			issue_branch(kind, 1'b0, ad, !b_wait, bd, 1'b0, 16'h0, coin[3], early, ta);
			repeat (3) begin
				check_bit("commit_ready", commit_ready, 1'b0);
				@(negedge clk);
			end
			if (!early) begin
				check_bit("commit_ready", commit_ready, 1'b0);
				broadcast(ta, ad);
			end
			if (b_wait) begin
				check_bit("commit_ready", commit_ready, 1'b0);
				broadcast(ta + 1'b1, bd);
			end
			commit_head();
		end

		// full order queue holds off issue
		repeat (4) issue_random_branch();
		check_bit("issue_ready", issue_ready, 1'b0);
		while (model_q.size() > 0)
			commit_head();

		// fill every slot, then calls and returns
		repeat (depth + n_calls) do_call(addr_t'($random(seed)));
		repeat (n_calls) do_ret();

		// calls and returns behind a mispredicted branch
		for (int r = 0; r < n_rounds; r++) begin
			ta   = $random(seed);
			ad   = $random(seed);
			im   = $random(seed);
			pred = !ref_taken(cmp_le, ad, {{16{im[15]}}, im});
			issue_branch(cmp_le, 1'b0, ad, 1'b1, 32'h0, 1'b1, im, pred, 1'b0, ta);
			do_call(addr_t'($random(seed)));
			issue_random_branch();
			do_ret();
			do_call(addr_t'($random(seed)));
			do_call(addr_t'($random(seed)));
			issue_random_branch();
			do_ret();
			check_bit("commit_ready", commit_ready, 1'b0);
			broadcast(ta, ad);
			commit_head();
			check_addr("return_addr", return_addr, model_stack[model_sp]);
			repeat (3) begin
				check_bit("commit_ready", commit_ready, 1'b0);
				@(negedge clk);
			end
			repeat (3) do_ret();
		end

		$display("run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issue_valid,
	output logic                  issue_ready,
	input  branch_pkg::cmp_kind_t cmp_kind,
	input  logic                  a_valid,
	input  branch_pkg::tag_t      a_tag,
	input  branch_pkg::word_t     a_data,
	input  logic                  b_valid,
	input  branch_pkg::tag_t      b_tag,
	input  branch_pkg::word_t     b_data,
	input  logic                  use_imm,
	input  logic [15:0]           imm,
	input  logic                  prediction,
	input  branch_pkg::pattern_t  pattern_in,
	input  branch_pkg::addr_t     redirect_in,
	input  logic                  call_valid,
	output logic                  call_ready,
	input  branch_pkg::addr_t     call_addr,
	input  logic                  ret,
	output branch_pkg::addr_t     return_addr,
	input  logic                  commit_valid,
	output logic                  commit_ready,
	output logic                  failure,
	output branch_pkg::pattern_t  pattern_out,
	output branch_pkg::addr_t     redirect_addr,
	input  logic                  cdb_valid,
	input  branch_pkg::tag_t      cdb_tag,
	input  branch_pkg::word_t     cdb_data
);
	import branch_pkg::*;

	logic       issue;
	logic       commit;
	logic       resolve;
	logic       taken;
	logic       recover; // failed commit, wrong path dropped
	logic       oq_full;
	br_count_t  branch_count;
	stack_ptr_t sp;
	stack_ptr_t head_sp;

	assign issue_ready = !oq_full;
	assign issue       = issue_valid && issue_ready;
	assign commit      = commit_valid && commit_ready;

	branch_compare_queue u_cmpq (
		.clk       (clk),
		.reset     (reset),
		.issue     (issue),
		.cmp_kind  (cmp_kind),
		.a_valid   (a_valid),
		.a_tag     (a_tag),
		.a_data    (a_data),
		.b_valid   (b_valid),
		.b_tag     (b_tag),
		.b_data    (b_data),
		.use_imm   (use_imm),
		.imm       (imm),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_data  (cdb_data),
		.flush     (recover),
		.resolve   (resolve),
		.taken     (taken)
	);

	branch_order_queue u_ordq (
		.clk           (clk),
		.reset         (reset),
		.issue         (issue),
		.prediction    (prediction),
		.pattern_in    (pattern_in),
		.redirect_in   (redirect_in),
		.sp_in         (sp),
		.resolve       (resolve),
		.taken         (taken),
		.commit_valid  (commit_valid),
		.commit_ready  (commit_ready),
		.failure       (failure),
		.pattern_out   (pattern_out),
		.redirect_addr (redirect_addr),
		.head_sp       (head_sp),
		.count         (branch_count),
		.full          (oq_full),
		.recover       (recover)
	);

	return_addr_stack u_ras (
		.clk          (clk),
		.reset        (reset),
		.call_valid   (call_valid),
		.call_ready   (call_ready),
		.call_addr    (call_addr),
		.ret          (ret),
		.commit       (commit),
		.recover      (recover),
		.branch_count (branch_count),
		.head_sp      (head_sp),
		.sp           (sp),
		.return_addr  (return_addr)
	);

endmodule

`default_nettype wire

//--- verilog/return_addr_stack.sv
`timescale 1ns/1ps
`default_nettype none
`include "branch_settings.svh"

module return_addr_stack (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   call_valid,
	output logic                   call_ready,
	input  branch_pkg::addr_t      call_addr,
	input  logic                   ret,
	input  logic                   commit,
	input  logic                   recover,
	input  branch_pkg::br_count_t  branch_count,
	input  branch_pkg::stack_ptr_t head_sp,
	output branch_pkg::stack_ptr_t sp,
	output branch_pkg::addr_t      return_addr
);
	import branch_pkg::*;

	localparam int depth = 2 ** `STACK_LOG;
	localparam int bk_w  = $clog2(`BACKUP_ENTRIES + 1);

	addr_t      stack_q [depth];
	addr_t      stack_nxt [depth];
	stack_ptr_t sp_nxt;
	stack_ptr_t above; // slot a call writes
	logic       push;
	logic       pop;
	logic       save;
	br_count_t  remaining; // branches still in flight after this edge

	// backup buffer, oldest at index 0
	logic [bk_w-1:0] bk_count;
	logic [bk_w-1:0] bk_count_nxt;
	br_count_t       bk_tag [`BACKUP_ENTRIES];
	stack_ptr_t      bk_idx [`BACKUP_ENTRIES];
	addr_t           bk_addr [`BACKUP_ENTRIES];
	br_count_t       bk_tag_nxt [`BACKUP_ENTRIES];
	stack_ptr_t      bk_idx_nxt [`BACKUP_ENTRIES];
	addr_t           bk_addr_nxt [`BACKUP_ENTRIES];

	assign call_ready = bk_count < bk_w'(`BACKUP_ENTRIES)
		|| (commit && bk_tag[0] == br_count_t'(1));
	assign push      = call_valid && call_ready && !recover;
	assign pop       = ret && !recover;
	assign above     = sp + 1'b1;
	assign remaining = branch_count - br_count_t'(commit);
	assign save      = push && remaining != '0;

	// tags only grow toward the back, so released entries sit at the front
	always_comb begin
		int drop;
		drop = 0;
		for (int i = 0; i < `BACKUP_ENTRIES; i++) begin
			if (commit && i < int'(bk_count) && bk_tag[i] == br_count_t'(1)) begin
				drop++;
			end
		end
		for (int i = 0; i < `BACKUP_ENTRIES; i++) begin
			if (i + drop < int'(bk_count)) begin
				bk_tag_nxt[i]  = bk_tag[i + drop] - br_count_t'(commit);
				bk_idx_nxt[i]  = bk_idx[i + drop];
				bk_addr_nxt[i] = bk_addr[i + drop];
			end else begin
				bk_tag_nxt[i]  = remaining;
				bk_idx_nxt[i]  = above;
				bk_addr_nxt[i] = stack_q[above]; // slot about to be overwritten
			end
		end
		if (recover) begin
			bk_count_nxt = '0;
		end else begin
			bk_count_nxt = bk_w'(int'(bk_count) - drop + int'(save));
		end
	end

	always_comb begin
		for (int i = 0; i < depth; i++) begin
			stack_nxt[i] = stack_q[i];
			if (recover) begin
				// youngest first so the oldest save lands last
				for (int j = `BACKUP_ENTRIES - 1; j >= 0; j--) begin
					if (j < int'(bk_count) && int'(bk_idx[j]) == i) begin
						stack_nxt[i] = bk_addr[j];
					end
				end
			end else if (push && int'(above) == i) begin
				stack_nxt[i] = call_addr;
			end
		end
	end

	always_comb begin
		if (recover) begin
			sp_nxt = head_sp;
		end else if (push) begin
			sp_nxt = above;
		end else if (pop) begin
			sp_nxt = sp - 1'b1;
		end else begin
			sp_nxt = sp;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sp       <= '1;
			bk_count <= '0;
		end else begin
			sp       <= sp_nxt;
			bk_count <= bk_count_nxt;
		end
	end

	always_ff @(posedge clk) begin
		stack_q     <= stack_nxt;
		bk_tag      <= bk_tag_nxt;
		bk_idx      <= bk_idx_nxt;
		bk_addr     <= bk_addr_nxt;
		return_addr <= stack_nxt[sp_nxt];
	end

	// every saved slot belongs to a branch the order queue still holds
	assert property (@(posedge clk) disable iff (reset)
		bk_count != '0 |-> branch_count != '0);

endmodule

`default_nettype wire

//--- verilog/branch_order_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "branch_settings.svh"

module branch_order_queue (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   issue,
	input  logic                   prediction,
	input  branch_pkg::pattern_t   pattern_in,
	input  branch_pkg::addr_t      redirect_in,
	input  branch_pkg::stack_ptr_t sp_in,
	input  logic                   resolve,
	input  logic                   taken,
	input  logic                   commit_valid,
	output logic                   commit_ready,
	output logic                   failure,
	output branch_pkg::pattern_t   pattern_out,
	output branch_pkg::addr_t      redirect_addr,
	output branch_pkg::stack_ptr_t head_sp,
	output branch_pkg::br_count_t  count,
	output logic                   full,
	output logic                   recover
);
	import branch_pkg::*;

	br_count_t  rcount; // resolved branches at the front
	br_count_t  res_slot;
	logic       commit;

	logic       pf_q [`BR_ENTRIES]; // prediction until resolved, then failure
	pattern_t   pat_q [`BR_ENTRIES];
	addr_t      redir_q [`BR_ENTRIES];
	stack_ptr_t sp_q [`BR_ENTRIES];

	logic       pf_nxt [`BR_ENTRIES];
	pattern_t   pat_nxt [`BR_ENTRIES];
	addr_t      redir_nxt [`BR_ENTRIES];
	stack_ptr_t sp_nxt [`BR_ENTRIES];

	assign commit_ready  = rcount != '0;
	assign commit        = commit_valid && commit_ready;
	assign failure       = pf_q[0];
	assign pattern_out   = pat_q[0];
	assign redirect_addr = redir_q[0];
	assign head_sp       = sp_q[0];
	assign recover       = commit && pf_q[0];
	assign full          = count == br_count_t'(`BR_ENTRIES) && !commit;
	assign res_slot      = rcount - br_count_t'(commit); // oldest unresolved after the shift

	always_comb begin
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			if (i + int'(commit) < int'(count)) begin
				pf_nxt[i]    = pf_q[i + int'(commit)];
				pat_nxt[i]   = pat_q[i + int'(commit)];
				redir_nxt[i] = redir_q[i + int'(commit)];
				sp_nxt[i]    = sp_q[i + int'(commit)];
			end else begin
				pf_nxt[i]    = prediction;
				pat_nxt[i]   = pattern_in;
				redir_nxt[i] = redirect_in;
				sp_nxt[i]    = sp_in;
			end
			if (resolve && i == int'(res_slot)) begin
				pf_nxt[i] = pf_nxt[i] ^ taken;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || recover) begin
			count  <= '0;
			rcount <= '0;
		end else begin
			count  <= count - br_count_t'(commit) + br_count_t'(issue);
			rcount <= rcount + br_count_t'(resolve) - br_count_t'(commit);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			pf_q[i]    <= pf_nxt[i];
			pat_q[i]   <= pat_nxt[i];
			redir_q[i] <= redir_nxt[i];
			sp_q[i]    <= sp_nxt[i];
		end
	end

	// compare queue never runs ahead of the branches held here
	assert property (@(posedge clk) disable iff (reset)
		resolve |-> rcount < count);

endmodule

`default_nettype wire

//--- verilog/branch_compare_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "branch_settings.svh"

module branch_compare_queue (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issue,
	input  branch_pkg::cmp_kind_t cmp_kind,
	input  logic                  a_valid,
	input  branch_pkg::tag_t      a_tag,
	input  branch_pkg::word_t     a_data,
	input  logic                  b_valid,
	input  branch_pkg::tag_t      b_tag,
	input  branch_pkg::word_t     b_data,
	input  logic                  use_imm,
	input  logic [15:0]           imm,
	input  logic                  cdb_valid,
	input  branch_pkg::tag_t      cdb_tag,
	input  branch_pkg::word_t     cdb_data,
	input  logic                  flush,
	output logic                  resolve,
	output logic                  taken
);
	import branch_pkg::*;

	br_count_t count;
	cmp_kind_t kind_q [`BR_ENTRIES];
	logic      a_ok_q [`BR_ENTRIES];
	tag_t      a_tag_q [`BR_ENTRIES];
	word_t     a_val_q [`BR_ENTRIES];
	logic      b_ok_q [`BR_ENTRIES];
	tag_t      b_tag_q [`BR_ENTRIES];
	word_t     b_val_q [`BR_ENTRIES];

	// entries after this cycle's result bus
	logic  a_ok_upd [`BR_ENTRIES];
	word_t a_val_upd [`BR_ENTRIES];
	logic  b_ok_upd [`BR_ENTRIES];
	word_t b_val_upd [`BR_ENTRIES];

	logic  new_a_ok;
	word_t new_a_val;
	logic  new_b_ok;
	word_t new_b_val;
	logic  int_kind;
	logic  fle;

	always_comb begin
		int_kind  = cmp_kind == cmp_eq || cmp_kind == cmp_le;
		new_a_ok  = a_valid || (cdb_valid && cdb_tag == a_tag);
		new_a_val = a_valid ? a_data : cdb_data;
		if (int_kind && use_imm) begin
			new_b_ok  = 1'b1;
			new_b_val = {{16{imm[15]}}, imm};
		end else if (cmp_kind == cmp_fz) begin
			new_b_ok  = 1'b1; // b not looked at
			new_b_val = b_data;
		end else begin
			new_b_ok  = b_valid || (cdb_valid && cdb_tag == b_tag);
			new_b_val = b_valid ? b_data : cdb_data;
		end
	end

	always_comb begin
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			a_ok_upd[i]  = a_ok_q[i] || (cdb_valid && cdb_tag == a_tag_q[i]);
			a_val_upd[i] = a_ok_q[i] ? a_val_q[i] : cdb_data;
			b_ok_upd[i]  = b_ok_q[i] || (cdb_valid && cdb_tag == b_tag_q[i]);
			b_val_upd[i] = b_ok_q[i] ? b_val_q[i] : cdb_data;
		end
	end

	assign resolve = count != '0 && a_ok_q[0] && b_ok_q[0];

	float_le_compare u_fle (
		.a  (a_val_q[0]),
		.b  (b_val_q[0]),
		.le (fle)
	);

	always_comb begin
		case (kind_q[0])
			cmp_eq:  taken = a_val_q[0] == b_val_q[0];
			cmp_le:  taken = $signed(a_val_q[0]) <= $signed(b_val_q[0]);
			cmp_fle: taken = fle;
			default: taken = a_val_q[0][30:23] == 8'd0; // zero exponent
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			count <= '0;
		end else begin
			count <= count - br_count_t'(resolve) + br_count_t'(issue);
		end
	end

	// shift by one on resolve, new entry lands behind the survivors
	always_ff @(posedge clk) begin
		for (int i = 0; i < `BR_ENTRIES; i++) begin
			if (i + int'(resolve) < int'(count)) begin
				kind_q[i]  <= kind_q[i + int'(resolve)];
				a_ok_q[i]  <= a_ok_upd[i + int'(resolve)];
				a_tag_q[i] <= a_tag_q[i + int'(resolve)];
				a_val_q[i] <= a_val_upd[i + int'(resolve)];
				b_ok_q[i]  <= b_ok_upd[i + int'(resolve)];
				b_tag_q[i] <= b_tag_q[i + int'(resolve)];
				b_val_q[i] <= b_val_upd[i + int'(resolve)];
			end else begin
				kind_q[i]  <= cmp_kind;
				a_ok_q[i]  <= new_a_ok;
				a_tag_q[i] <= a_tag;
				a_val_q[i] <= new_a_val;
				b_ok_q[i]  <= new_b_ok;
				b_tag_q[i] <= b_tag;
				b_val_q[i] <= new_b_val;
			end
		end
	end

	// issue_ready from the order queue keeps a full compare queue closed
	assert property (@(posedge clk) disable iff (reset)
		count == br_count_t'(`BR_ENTRIES) |-> !issue);

endmodule

`default_nettype wire

//--- verilog/float_le_compare.sv
`timescale 1ns/1ps
`default_nettype none

module float_le_compare (
	input  branch_pkg::word_t a,
	input  branch_pkg::word_t b,
	output logic              le
);
	logic both_zero;
	logic mag_le;
	logic mag_ge;

	assign both_zero = a[30:0] == 31'd0 && b[30:0] == 31'd0; // +0 equals -0
	assign mag_le    = a[30:0] <= b[30:0];
	assign mag_ge    = a[30:0] >= b[30:0];

	// sign-magnitude order, exponent over mantissa falls out of the bit layout
	always_comb begin
		if (both_zero) begin
			le = 1'b1;
		end else if (a[31] != b[31]) begin
			le = a[31]; // negative side is smaller
		end else if (a[31]) begin
			le = mag_ge; // both negative
		end else begin
			le = mag_le;
		end
	end

endmodule

`default_nettype wire

//--- verilog/branch_pkg.sv
`default_nettype none
`include "branch_settings.svh"

package branch_pkg;

	typedef logic [31:0] word_t; // operand value, int or single
	typedef logic [`TAG_WIDTH-1:0] tag_t;
	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`PATTERN_WIDTH-1:0] pattern_t;
	typedef logic [`STACK_LOG-1:0] stack_ptr_t;

	// 0 .. BR_ENTRIES inclusive
	typedef logic [$clog2(`BR_ENTRIES + 1)-1:0] br_count_t;

	// float kinds first, integer kinds in the upper half
	typedef enum logic [1:0] {
		cmp_fz,
		cmp_fle,
		cmp_eq,
		cmp_le
	} cmp_kind_t;

endpackage

`default_nettype wire

//--- branch_settings.svh
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// compare queue and order queue share one depth
`define BR_ENTRIES 4

// saved stack slots for wrong-path repair
`define BACKUP_ENTRIES 4

`define TAG_WIDTH 4
`define ADDR_WIDTH 14
`define PATTERN_WIDTH 8

// return stack holds 2**STACK_LOG addresses
`define STACK_LOG 3

`endif
